// File: histPeakTop.f
+incdir+common
common/histPeakPkg.sv
hw/sampleBinner.sv
histogram/histogramBank.sv
histogram/histogramUpdater.sv
histogram/peakSearch.sv
hw/peakReport.sv
hw/histPeakTop.sv
verif/histPeakTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module histPeakTb \
    -f histPeakTop.f -o histPeakSim || { echo "build failed"; exit 1; }

out=$(./obj_dir/histPeakSim) ; echo "$out"

echo "$out" | grep -q "TEST PASSED" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

// File: verif/histPeakTb.sv
`timescale 1ns/1ps
`include "histPeak_settings.svh"

module histPeakTb
    import histPeakPkg::*;
();

    localparam int CountMax = (1 << `HP_COUNT_BITS) - 1;
    localparam int TotalMax = (1 << `HP_TOTAL_BITS) - 1;
    localparam int LowBits  = `HP_SAMPLE_BITS - `HP_BIN_BITS;

    logic                       clk;
    logic                       res;
    logic                       sampleStrobe;
    logic [`HP_SAMPLE_BITS-1:0] sample;
    logic                       frameEnd;
    logic                       scanBusy;
    logic                       resultStrobe;
    peakResult_t                result;

    int          refCount [`HP_BIN_COUNT]; // model histogram without saturation
    int          refTotal;
    peakResult_t expResult;
    int          reqCount;     // frames handed to the compare process
    int          doneCount;    // frames it has judged
    int          checkErrs;
    int          errsAtStart;
    int          strobeWait;
    logic        strobeMissed;
    logic        timedOut;
    int          passCount;
    int          failCount;
    int          testNum;

    histPeakTop uut (
        .clk(clk), .res(res), .sampleStrobe(sampleStrobe), .sample(sample),
        .frameEnd(frameEnd), .scanBusy(scanBusy), .resultStrobe(resultStrobe),
        .result(result)
    );

    always #5 clk = ~clk;

    // strictly greater keeps the lowest bin on a tie
    function automatic peakResult_t expectedResult();
        peakResult_t want;
        int          best;
        int          cnt;
        want.peakBin = '0;
        best         = 0;
        for (int b = 0; b < `HP_BIN_COUNT; b++) begin
            cnt = (refCount[b] > CountMax) ? CountMax : refCount[b];
            if (cnt > best) begin
                best         = cnt;
                want.peakBin = `HP_BIN_BITS'(b);
            end
        end
        want.peakCount = `HP_COUNT_BITS'(best);
        want.total     = `HP_TOTAL_BITS'((refTotal > TotalMax) ? TotalMax : refTotal);
        return want;
    endfunction

    function automatic logic [`HP_SAMPLE_BITS-1:0] sampleInBin(
        input logic [`HP_BIN_BITS-1:0] bin
    );
        logic [LowBits-1:0] low;
        low = LowBits'($urandom);
        return {bin, low};
    endfunction

    task automatic clearModel();
        foreach (refCount[i]) begin
            refCount[i] = 0;
        end
        refTotal = 0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            sampleStrobe <= 1'b0;
        end
    endtask

    task automatic sendSample(
        input logic [`HP_SAMPLE_BITS-1:0] value,
        input int                         gap,
        input bit                         counted
    );
        logic [`HP_BIN_BITS-1:0] bin;
        bin = value[`HP_SAMPLE_BITS-1 -: `HP_BIN_BITS]; // bin is the top bits
        @(posedge clk);
        sampleStrobe <= 1'b1;
        sample       <= value;
        if (counted) begin
            refCount[bin] += 1;
            refTotal += 1;
        end
        idleCycles(gap);
    endtask

    task automatic startFrame();
        expResult   = expectedResult();
        errsAtStart = checkErrs;
        clearModel();
        @(posedge clk);
        sampleStrobe <= 1'b0; // frame end right behind the last sample
        frameEnd     <= 1'b1;
        reqCount++;
        @(posedge clk);
        frameEnd <= 1'b0;
    endtask

    task automatic waitScanBusy();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!scanBusy && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!scanBusy) begin
            $display("scanBusy did not rise after frame end");
            timedOut = 1'b1;
        end
    endtask

    task automatic finishFrame(input string name);
        int waited;
        bit ok;
        waited = 0;
        while (doneCount != reqCount && waited < 300) begin
            @(posedge clk);
            waited++;
        end
        if (doneCount != reqCount) begin
            $display("no verdict from the compare process for %s", name);
            timedOut = 1'b1;
        end
        ok = (doneCount == reqCount) && !strobeMissed && (checkErrs == errsAtStart);
        testNum++;
        if (ok) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("test %0d %s: %s", testNum, name, ok ? "pass" : "fail");
    endtask

    // compare process judges one frame per request
    initial begin
        doneCount    = 0;
        checkErrs    = 0;
        strobeMissed = 1'b0;
        forever begin
            @(negedge clk);
            if (reqCount != doneCount) begin
                strobeWait = 0;
                while (!resultStrobe && strobeWait < 200) begin
                    @(negedge clk);
                    strobeWait++;
                end
                if (!resultStrobe) begin
                    $display("resultStrobe did not arrive within 200 cycles");
                    strobeMissed = 1'b1;
                end else begin
                    assert (result.peakBin == expResult.peakBin) else begin
                        $display("ERR result.peakBin exp 0x%0h got 0x%0h",
                                 expResult.peakBin, result.peakBin);
                        checkErrs++;
                    end
                    assert (result.peakCount == expResult.peakCount) else begin
                        $display("ERR result.peakCount exp 0x%0h got 0x%0h",
                                 expResult.peakCount, result.peakCount);
                        checkErrs++;
                    end
                    assert (result.total == expResult.total) else begin
                        $display("ERR result.total exp 0x%0h got 0x%0h",
                                 expResult.total, result.total);
                        checkErrs++;
                    end
                    assert (!scanBusy) else begin // busy ends with the result
                        $display("ERR scanBusy exp 0x0 got 0x%0h", scanBusy);
                        checkErrs++;
                    end
                end
                doneCount++;
            end
        end
    end

    initial begin
        clk          = 1'b0;
        res          = 1'b0;
        sampleStrobe = 1'b0;
        sample       = '0;
        frameEnd     = 1'b0;
        reqCount     = 0;
        timedOut     = 1'b0;
        passCount    = 0;
        failCount    = 0;
        testNum      = 0;
        void'($urandom(30));
        clearModel();
        repeat (10) @(posedge clk);
        res <= 1'b1;
        idleCycles(70); // bank zeroes itself

        repeat (300) sendSample(`HP_SAMPLE_BITS'($urandom), $urandom_range(3), 1'b1);
        startFrame();
        finishFrame("random frame");

        for (int i = 0; i < 6; i++) begin
            sendSample(sampleInBin(`HP_BIN_BITS'(i * 9)), 3, 1'b1);
        end
        sendSample(sampleInBin(`HP_BIN_BITS'(2)), 2, 1'b1);
        repeat (50) sendSample(sampleInBin(`HP_BIN_BITS'(33)), 0, 1'b1); // forwarding and drain
        startFrame();
        finishFrame("back-to-back same bin");

        repeat (9) begin
            sendSample(sampleInBin(`HP_BIN_BITS'(45)), 0, 1'b1);
            sendSample(sampleInBin(`HP_BIN_BITS'(12)), 0, 1'b1);
        end
        repeat (2) sendSample(sampleInBin(`HP_BIN_BITS'(3)), 2, 1'b1);
        startFrame();
        finishFrame("tie");

        repeat (1100) sendSample(sampleInBin(`HP_BIN_BITS'(58)), 0, 1'b1);
        startFrame();
        finishFrame("saturation");

        repeat (5) sendSample(sampleInBin(`HP_BIN_BITS'(20)), 1, 1'b1);
        startFrame();
        waitScanBusy();
        repeat (30) sendSample(sampleInBin(`HP_BIN_BITS'(50)), 0, 1'b0); // dropped
        idleCycles(1);
        finishFrame("drop during scan");
        repeat (3) sendSample(sampleInBin(`HP_BIN_BITS'(7)), 2, 1'b1);
        repeat (2) sendSample(sampleInBin(`HP_BIN_BITS'(50)), 2, 1'b1);
        startFrame();
        finishFrame("cleared bins");

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && !timedOut && !strobeMissed) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hw/histPeakTop.sv
`timescale 1ns/1ps
`include "histPeak_settings.svh"

module histPeakTop
    import histPeakPkg::*;
(
    input  logic                       clk,
    input  logic                       res,
    input  logic                       sampleStrobe,
    input  logic [`HP_SAMPLE_BITS-1:0] sample,
    input  logic                       frameEnd,
    output logic                       scanBusy,
    output logic                       resultStrobe,
    output peakResult_t                result
);

    binEvent_t                 binEvent;
    memReq_t                   updReq;
    memReq_t                   scanReq;
    logic                      scanActive;
    logic [`HP_COUNT_BITS-1:0] rdData;
    logic                      peakFound;
    logic [`HP_BIN_BITS-1:0]   peakBin;
    logic [`HP_COUNT_BITS-1:0] peakCount;

    sampleBinner binner (
        .clk(clk), .res(res), .sampleStrobe(sampleStrobe), .sample(sample),
        .scanActive(scanActive), .binEvent(binEvent)
    );

    histogramUpdater updater (
        .clk(clk), .res(res), .binEvent(binEvent), .rdData(rdData), .updReq(updReq)
    );

    histogramBank bank (
        .clk(clk), .res(res), .updReq(updReq), .scanReq(scanReq),
        .scanActive(scanActive), .rdData(rdData)
    );

    peakSearch search (
        .clk(clk), .res(res), .frameEnd(frameEnd), .scanActive(scanActive),
        .scanReq(scanReq), .rdData(rdData), .peakFound(peakFound),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    peakReport report (
        .clk(clk), .res(res), .binEvent(binEvent), .peakFound(peakFound),
        .peakBin(peakBin), .peakCount(peakCount), .resultStrobe(resultStrobe),
        .result(result)
    );

    assign scanBusy = scanActive; // tells the source that samples are dropped

endmodule

// File: hw/peakReport.sv
`timescale 1ns/1ps
`include "histPeak_settings.svh"

module peakReport
    import histPeakPkg::*;
(
    input  logic                      clk,
    input  logic                      res,
    input  binEvent_t                 binEvent,
    input  logic                      peakFound,
    input  logic [`HP_BIN_BITS-1:0]   peakBin,
    input  logic [`HP_COUNT_BITS-1:0] peakCount,
    output logic                      resultStrobe,
    output peakResult_t               result
);

    logic [`HP_TOTAL_BITS-1:0] sampleTotal;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            resultStrobe <= 1'b0;
            sampleTotal  <= '0;
        end else begin
            resultStrobe <= peakFound;
            if (peakFound) begin
                sampleTotal <= '0; // next frame starts counting
            end else if (binEvent.valid && sampleTotal != '1) begin
                sampleTotal <= sampleTotal + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (peakFound) begin
            result.peakBin   <= peakBin;
            result.peakCount <= peakCount;
            result.total     <= sampleTotal;
        end
    end

endmodule

// File: histogram/peakSearch.sv
`timescale 1ns/1ps
`include "histPeak_settings.svh"

module peakSearch
    import histPeakPkg::*;
(
    input  logic                      clk,
    input  logic                      res,
    input  logic                      frameEnd,
    output logic                      scanActive,
    output memReq_t                   scanReq,
    input  logic [`HP_COUNT_BITS-1:0] rdData,
    output logic                      peakFound,
    output logic [`HP_BIN_BITS-1:0]   peakBin,
    output logic [`HP_COUNT_BITS-1:0] peakCount
);

    typedef enum logic [2:0] {
        sIdle,
        sDrain,
        sScan,
        sFinish,
        sDone
    } scanState_t;

    scanState_t                state;
    scanState_t                nextState;

    logic                      drainCnt;
    logic [`HP_BIN_BITS-1:0]   scanAddr;
    logic                      clrEn;     // also marks rdData valid
    logic [`HP_BIN_BITS-1:0]   clrAddr;
    logic [`HP_BIN_BITS-1:0]   maxBin;
    logic [`HP_COUNT_BITS-1:0] maxCount;

    always_comb begin
        nextState = state;
        case (state)
            sIdle:   if (frameEnd) nextState = sDrain;
            sDrain:  if (drainCnt) nextState = sScan;     // two cycles for updater writes
            sScan:   if (&scanAddr) nextState = sFinish;
            sFinish: nextState = sDone;                   // last compare
            sDone:   nextState = sIdle;
            default: nextState = sIdle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= sIdle;
            drainCnt <= 1'b0;
            scanAddr <= '0;
            clrEn    <= 1'b0;
        end else begin
            state    <= nextState;
            drainCnt <= (state == sDrain) ? drainCnt + 1'b1 : 1'b0;
            scanAddr <= (state == sScan) ? scanAddr + 1'b1 : '0;
            clrEn    <= (state == sScan);
        end
    end

    // strictly greater, so ties keep the lower bin
    always_ff @(posedge clk) begin
        clrAddr <= scanAddr;
        if (state == sDrain) begin
            maxBin   <= '0;
            maxCount <= '0;
        end else if (clrEn && rdData > maxCount) begin
            maxBin   <= clrAddr;
            maxCount <= rdData;
        end
    end

    always_comb begin
        scanReq.rdEn   = (state == sScan);
        scanReq.rdAddr = scanAddr;
        scanReq.wrEn   = clrEn;   // clear the bin read last cycle
        scanReq.wrAddr = clrAddr;
        scanReq.wrData = '0;
    end

    assign scanActive = (state != sIdle);
    assign peakFound  = (state == sDone);
    assign peakBin    = maxBin;
    assign peakCount  = maxCount;

endmodule

// File: histogram/histogramUpdater.sv
`timescale 1ns/1ps
`include "histPeak_settings.svh"

module histogramUpdater
    import histPeakPkg::*;
(
    input  logic                      clk,
    input  logic                      res,
    input  binEvent_t                 binEvent,
    input  logic [`HP_COUNT_BITS-1:0] rdData,
    output memReq_t                   updReq
);

    localparam logic [`HP_COUNT_BITS-1:0] CountMax = '1;

    // stage 1, waiting for read data
    logic                      s1Valid;
    logic [`HP_BIN_BITS-1:0]   s1Bin;

    // stage 2, write in flight
    logic                      wrValid;
    logic [`HP_BIN_BITS-1:0]   wrBin;
    logic [`HP_COUNT_BITS-1:0] wrCount;

    logic [`HP_COUNT_BITS-1:0] baseCount;
    logic [`HP_COUNT_BITS-1:0] nextCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            wrValid <= 1'b0;
        end else begin
            s1Valid <= binEvent.valid;
            wrValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= binEvent.bin;
        if (s1Valid) begin
            wrBin   <= s1Bin;
            wrCount <= nextCount;
        end
    end

    // the RAM still holds the old value when the previous event hit the same bin,
    // take the count that is being written instead
    always_comb begin
        if (wrValid && wrBin == s1Bin) begin
            baseCount = wrCount;
        end else begin
            baseCount = rdData;
        end
        nextCount = (baseCount == CountMax) ? baseCount : baseCount + 1'b1; // saturate
    end

    always_comb begin
        updReq.rdEn   = binEvent.valid; // read in the arrival cycle
        updReq.rdAddr = binEvent.bin;
        updReq.wrEn   = wrValid;
        updReq.wrAddr = wrBin;
        updReq.wrData = wrCount;
    end

endmodule

// File: histogram/histogramBank.sv
`timescale 1ns/1ps
`include "histPeak_settings.svh"

module histogramBank
    import histPeakPkg::*;
(
    input  logic                      clk,
    input  logic                      res,
    input  memReq_t                   updReq,
    input  memReq_t                   scanReq,
    input  logic                      scanActive,
    output logic [`HP_COUNT_BITS-1:0] rdData
);

    logic [`HP_COUNT_BITS-1:0] mem [`HP_BIN_COUNT];

    logic                      clrBusy;
    logic [`HP_BIN_BITS-1:0]   clrAddr;

    logic                      wrEn;
    logic [`HP_BIN_BITS-1:0]   wrAddr;
    logic [`HP_COUNT_BITS-1:0] wrData;
    logic                      rdEn;
    logic [`HP_BIN_BITS-1:0]   rdAddr;

    // zero one bin per cycle after reset
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clrBusy <= 1'b1;
            clrAddr <= '0;
        end else if (clrBusy) begin
            clrAddr <= clrAddr + 1'b1;
            if (clrAddr == `HP_BIN_BITS'(`HP_BIN_COUNT - 1)) begin
                clrBusy <= 1'b0;
            end
        end
    end

    // the scanner owns a port only when it uses it, so updates still pending
    // at frame end can drain while the scan FSM waits
    always_comb begin
        if (clrBusy) begin
            wrEn   = 1'b1;
            wrAddr = clrAddr;
            wrData = '0;
        end else if (scanActive && scanReq.wrEn) begin
            wrEn   = 1'b1;
            wrAddr = scanReq.wrAddr;
            wrData = scanReq.wrData;
        end else begin
            wrEn   = updReq.wrEn;
            wrAddr = updReq.wrAddr;
            wrData = updReq.wrData;
        end
        rdEn   = (scanActive && scanReq.rdEn) || updReq.rdEn;
        rdAddr = (scanActive && scanReq.rdEn) ? scanReq.rdAddr : updReq.rdAddr;
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        if (rdEn) begin
            rdData <= (wrEn && wrAddr == rdAddr) ? wrData : mem[rdAddr]; // write-first
        end
    end

endmodule

// File: hw/sampleBinner.sv
`timescale 1ns/1ps
`include "histPeak_settings.svh"

module sampleBinner
    import histPeakPkg::*;
(
    input  logic                       clk,
    input  logic                       res,
    input  logic                       sampleStrobe,
    input  logic [`HP_SAMPLE_BITS-1:0] sample,
    input  logic                       scanActive,
    output binEvent_t                  binEvent
);

    logic                    eventValid;
    logic [`HP_BIN_BITS-1:0] eventBin;

    // strobe is dropped while the scanner owns the memory
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            eventValid <= 1'b0;
        end else begin
            eventValid <= sampleStrobe && !scanActive;
        end
    end

    // bin is just the top bits of the sample
    always_ff @(posedge clk) begin
        if (sampleStrobe) begin
            eventBin <= sample[`HP_SAMPLE_BITS-1 -: `HP_BIN_BITS];
        end
    end

    always_comb begin
        binEvent.valid = eventValid;
        binEvent.bin   = eventBin;
    end

endmodule

// File: common/histPeakPkg.sv
`include "histPeak_settings.svh"

package histPeakPkg;

    // one accepted sample, already reduced to its bin
    typedef struct packed {
        logic                      valid;
        logic [`HP_BIN_BITS-1:0]   bin;
    } binEvent_t;

    // request from one client of the histogram memory
    typedef struct packed {
        logic                      rdEn;
        logic [`HP_BIN_BITS-1:0]   rdAddr;
        logic                      wrEn;
        logic [`HP_BIN_BITS-1:0]   wrAddr;
        logic [`HP_COUNT_BITS-1:0] wrData;
    } memReq_t;

    // per-frame result
    typedef struct packed {
        logic [`HP_BIN_BITS-1:0]   peakBin;
        logic [`HP_COUNT_BITS-1:0] peakCount;
        logic [`HP_TOTAL_BITS-1:0] total;
    } peakResult_t;

endpackage

// File: common/histPeak_settings.svh
`ifndef HISTPEAK_SETTINGS_SVH
`define HISTPEAK_SETTINGS_SVH

// pixel sample width
`define HP_SAMPLE_BITS 12

// histogram geometry, keep HP_BIN_COUNT equal to 2**HP_BIN_BITS
`define HP_BIN_BITS    6
`define HP_BIN_COUNT   64

// per-bin count, saturates at all ones
`define HP_COUNT_BITS  10

// samples accepted per frame
`define HP_TOTAL_BITS  16

`endif
